// ==== common/bu_wag_pkg.sv ====
`default_nettype none

package bu_wag_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  localparam int BU_PARALLELISM = 8;   // Lanes written per beat
  localparam int LANE_W         = 32;  // Butterfly index / write address width
  localparam int CNT_W          = 16;  // Transfer length and fill counter width
  localparam int LANE_SEL_W     = 3;   // log2(BU_PARALLELISM)

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  // Bank phase, shared by both sequencers and the generators
  typedef enum logic [1:0] {
    PH_SEQ_IN    = 2'b00,  // Sequential fill
    PH_SEQ_OUT   = 2'b01,  // Sequential drain
    PH_IDLE      = 2'b10,  // Bank B only, waits on A
    PH_BUTTERFLY = 2'b11   // Butterfly compute
  } bank_phase_t;

  // One word per lane, lane i at bits [32*i +: 32]
  typedef logic [BU_PARALLELISM-1:0][LANE_W-1:0] lane_bus_t;

endpackage : bu_wag_pkg

`default_nettype wire

// ==== bank_ctrl/bank_ctrl_a.sv ====
`default_nettype none

module bank_ctrl_a (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           up_vld,
  input  logic                           butterfly_finish,
  input  logic                           seq_out_finish_a,
  input  logic [bu_wag_pkg::CNT_W-1:0]   length,
  output bu_wag_pkg::bank_phase_t        phase,
  output logic [bu_wag_pkg::CNT_W-1:0]   in_count,
  output logic                           butterfly_start,
  output logic                           seq_out_start
);

  import bu_wag_pkg::*;

  logic fill_last;  // Final beat of the transfer

  assign fill_last = (in_count == length - CNT_W'(BU_PARALLELISM));

  ////////////////////////////////////////////////////////////
  // Three-phase sequencer: fill, compute, drain
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase           <= PH_SEQ_IN;
      in_count        <= '0;
      butterfly_start <= 1'b0;
      seq_out_start   <= 1'b0;
    end else begin
      butterfly_start <= 1'b0;  // Pulses last one cycle
      seq_out_start   <= 1'b0;
      case (phase)
        PH_SEQ_IN: begin
          if (up_vld) begin
            if (fill_last) begin
              in_count        <= '0;
              phase           <= PH_BUTTERFLY;
              butterfly_start <= 1'b1;
            end else begin
              in_count <= in_count + CNT_W'(BU_PARALLELISM);
            end
          end
        end
        PH_BUTTERFLY: begin
          if (butterfly_finish) begin
            phase         <= PH_SEQ_OUT;
            seq_out_start <= 1'b1;
          end
        end
        PH_SEQ_OUT: begin
          if (seq_out_finish_a)
            phase <= PH_SEQ_IN;  // Back to filling
        end
        default: phase <= PH_SEQ_IN;  // A never idles
      endcase
    end
  end

endmodule : bank_ctrl_a

`default_nettype wire

// ==== bank_ctrl/bank_ctrl_b.sv ====
`default_nettype none

module bank_ctrl_b (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           up_vld,
  input  logic                           butterfly_finish,
  input  logic                           seq_out_finish,
  input  logic [bu_wag_pkg::CNT_W-1:0]   length,
  input  bu_wag_pkg::bank_phase_t        phase_a,
  input  logic                           butterfly_start_a,
  input  logic                           seq_out_start_a,
  input  logic                           seq_out_finish_a,
  output bu_wag_pkg::bank_phase_t        phase,
  output logic [bu_wag_pkg::CNT_W-1:0]   in_count,
  output logic                           butterfly_start,
  output logic                           seq_out_start
);

  import bu_wag_pkg::*;

  logic fill_last;
  logic bfly_free;     // A has left compute, or leaves it now
  logic seq_out_free;  // A has left drain, or leaves it now
  logic seq_in_free;   // A has left fill, or leaves it now

  assign fill_last    = (in_count == length - CNT_W'(BU_PARALLELISM));
  assign bfly_free    = (phase_a != PH_BUTTERFLY) || seq_out_start_a;
  assign seq_out_free = (phase_a != PH_SEQ_OUT) || seq_out_finish_a;
  assign seq_in_free  = (phase_a != PH_SEQ_IN) || butterfly_start_a;

  ////////////////////////////////////////////////////////////
  // Four-phase sequencer, trails bank A
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase           <= PH_IDLE;
      in_count        <= '0;
      butterfly_start <= 1'b0;
      seq_out_start   <= 1'b0;
    end else begin
      butterfly_start <= 1'b0;
      seq_out_start   <= 1'b0;
      case (phase)
        // Parked until an event from A frees the next resource
        PH_IDLE: begin
          if (butterfly_start_a) begin
            phase <= PH_SEQ_IN;
          end else if (seq_out_start_a) begin
            phase           <= PH_BUTTERFLY;
            butterfly_start <= 1'b1;
          end else if (seq_out_finish_a) begin
            phase         <= PH_SEQ_OUT;
            seq_out_start <= 1'b1;
          end
        end

        PH_SEQ_IN: begin
          if (up_vld) begin
            if (fill_last) begin
              in_count <= '0;
              if (bfly_free) begin
                phase           <= PH_BUTTERFLY;
                butterfly_start <= 1'b1;
              end else begin
                phase <= PH_IDLE;  // Engine still busy with A
              end
            end else begin
              in_count <= in_count + CNT_W'(BU_PARALLELISM);
            end
          end
        end

        PH_BUTTERFLY: begin
          if (butterfly_finish) begin
            if (seq_out_free) begin
              phase         <= PH_SEQ_OUT;
              seq_out_start <= 1'b1;
            end else begin
              phase <= PH_IDLE;  // A still draining
            end
          end
        end

        PH_SEQ_OUT: begin
          if (seq_out_finish) begin
            if (seq_in_free)
              phase <= PH_SEQ_IN;
            else
              phase <= PH_IDLE;  // A still owns the input stream
          end
        end

        default: phase <= PH_IDLE;
      endcase
    end
  end

endmodule : bank_ctrl_b

`default_nettype wire

// ==== verilog/write_addr_gen.sv ====
`default_nettype none

module write_addr_gen (
  input  logic                           clk,
  input  logic                           rst_n,
  input  bu_wag_pkg::bank_phase_t        phase,
  input  logic [bu_wag_pkg::CNT_W-1:0]   in_count,
  input  logic                           up_vld,
  input  logic                           bu_vld,
  input  bu_wag_pkg::lane_bus_t          bu_indx,
  output logic                           write_vld,
  output bu_wag_pkg::lane_bus_t          write_addr
);

  import bu_wag_pkg::*;

  logic [LANE_W-1:0] fill_addr;

  // Beat number, same in every lane during fill
  assign fill_addr = LANE_W'(in_count >> LANE_SEL_W);

  ////////////////////////////////////////////////////////////
  // Per-lane address register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      write_addr <= '0;
    end else begin
      case (phase)
        PH_SEQ_IN:    write_addr <= {BU_PARALLELISM{fill_addr}};
        PH_BUTTERFLY: write_addr <= bu_indx;  // Lane-wise index from engine
        PH_SEQ_OUT:   write_addr <= '0;
        default:      write_addr <= write_addr;  // Idle holds
      endcase
    end
  end

  // Write valid tracks the source of the current phase
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      write_vld <= 1'b0;
    end else begin
      case (phase)
        PH_SEQ_IN:    write_vld <= up_vld;
        PH_BUTTERFLY: write_vld <= bu_vld;
        default:      write_vld <= 1'b0;
      endcase
    end
  end

endmodule : write_addr_gen

`default_nettype wire

// ==== verilog/bu_write_addr_gen.sv ====
`default_nettype none

module bu_write_addr_gen (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           up_vld,
  input  logic                           bu_vld,
  input  logic                           butterfly_finish,
  input  logic                           seq_out_finish_a,
  input  logic                           seq_out_finish_b,
  input  logic [bu_wag_pkg::CNT_W-1:0]   length,   // Stable during a transfer
  input  bu_wag_pkg::lane_bus_t          bu_indx_a,
  input  bu_wag_pkg::lane_bus_t          bu_indx_b,
  output logic                           butterfly_start_a,
  output logic                           butterfly_start_b,
  output logic                           seq_out_start_a,
  output logic                           seq_out_start_b,
  output logic                           write_vld_a,
  output logic                           write_vld_b,
  output bu_wag_pkg::lane_bus_t          write_addr_a,
  output bu_wag_pkg::lane_bus_t          write_addr_b
);

  import bu_wag_pkg::*;

  bank_phase_t       phase_a;
  bank_phase_t       phase_b;
  logic [CNT_W-1:0]  in_count_a;
  logic [CNT_W-1:0]  in_count_b;

  ////////////////////////////////////////////////////////////
  // Bank sequencers
  ////////////////////////////////////////////////////////////

  bank_ctrl_a u_ctrl_a (
    .clk              (clk),
    .rst_n            (rst_n),
    .up_vld           (up_vld),
    .butterfly_finish (butterfly_finish),
    .seq_out_finish_a (seq_out_finish_a),
    .length           (length),
    .phase            (phase_a),
    .in_count         (in_count_a),
    .butterfly_start  (butterfly_start_a),
    .seq_out_start    (seq_out_start_a)
  );

  bank_ctrl_b u_ctrl_b (
    .clk               (clk),
    .rst_n             (rst_n),
    .up_vld            (up_vld),
    .butterfly_finish  (butterfly_finish),
    .seq_out_finish    (seq_out_finish_b),
    .length            (length),
    .phase_a           (phase_a),            // B watches A's resources
    .butterfly_start_a (butterfly_start_a),
    .seq_out_start_a   (seq_out_start_a),
    .seq_out_finish_a  (seq_out_finish_a),
    .phase             (phase_b),
    .in_count          (in_count_b),
    .butterfly_start   (butterfly_start_b),
    .seq_out_start     (seq_out_start_b)
  );

  ////////////////////////////////////////////////////////////
  // Address generators, one per bank
  ////////////////////////////////////////////////////////////

  write_addr_gen u_gen_a (
    .clk        (clk),
    .rst_n      (rst_n),
    .phase      (phase_a),
    .in_count   (in_count_a),
    .up_vld     (up_vld),
    .bu_vld     (bu_vld),
    .bu_indx    (bu_indx_a),
    .write_vld  (write_vld_a),
    .write_addr (write_addr_a)
  );

  write_addr_gen u_gen_b (
    .clk        (clk),
    .rst_n      (rst_n),
    .phase      (phase_b),
    .in_count   (in_count_b),
    .up_vld     (up_vld),
    .bu_vld     (bu_vld),
    .bu_indx    (bu_indx_b),
    .write_vld  (write_vld_b),
    .write_addr (write_addr_b)
  );

endmodule : bu_write_addr_gen

`default_nettype wire

// ==== tests/bu_write_addr_gen_sva.sv ====
`default_nettype none

module bu_write_addr_gen_sva (
  input logic                    clk,
  input logic                    rst_n,
  input bu_wag_pkg::bank_phase_t phase_a,
  input bu_wag_pkg::bank_phase_t phase_b,
  input logic                    butterfly_start_a,
  input logic                    butterfly_start_b,
  input logic                    seq_out_start_a,
  input logic                    seq_out_start_b,
  input logic                    write_vld_a
);

  import bu_wag_pkg::*;

  ////////////////////////////////////////////////////////////
  // Start pulses last one cycle
  ////////////////////////////////////////////////////////////

  a_bfly_start_a: assert property (@(posedge clk) disable iff (!rst_n)
    butterfly_start_a |=> !butterfly_start_a)
    else $error("butterfly_start_a high for two cycles");

  a_bfly_start_b: assert property (@(posedge clk) disable iff (!rst_n)
    butterfly_start_b |=> !butterfly_start_b)
    else $error("butterfly_start_b high for two cycles");

  a_out_start_a: assert property (@(posedge clk) disable iff (!rst_n)
    seq_out_start_a |=> !seq_out_start_a)
    else $error("seq_out_start_a high for two cycles");

  a_out_start_b: assert property (@(posedge clk) disable iff (!rst_n)
    seq_out_start_b |=> !seq_out_start_b)
    else $error("seq_out_start_b high for two cycles");

  // Registered valid, so the drain shows one cycle later
  a_drain_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    (phase_a == PH_SEQ_OUT) |=> !write_vld_a)
    else $error("write_vld_a high while bank A drains");

  // Engine is shared, one bank at a time
  a_bfly_excl: assert property (@(posedge clk) disable iff (!rst_n)
    (phase_b == PH_BUTTERFLY && $past(phase_b) != PH_BUTTERFLY) |-> (phase_a != PH_BUTTERFLY))
    else $error("bank B entered compute while bank A computes");

endmodule : bu_write_addr_gen_sva

bind bu_write_addr_gen bu_write_addr_gen_sva u_sva (
  .clk               (clk),
  .rst_n             (rst_n),
  .phase_a           (phase_a),
  .phase_b           (phase_b),
  .butterfly_start_a (butterfly_start_a),
  .butterfly_start_b (butterfly_start_b),
  .seq_out_start_a   (seq_out_start_a),
  .seq_out_start_b   (seq_out_start_b),
  .write_vld_a       (write_vld_a)
);

`default_nettype wire

// ==== tests/tb_bu_write_addr_gen.sv ====
`default_nettype none

module tb_bu_write_addr_gen;

  import bu_wag_pkg::*;

  localparam int WAIT_LIMIT = 64;  // Cycles allowed per wait

  logic             clk = 1'b0;
  logic             rst_n;
  logic             up_vld;
  logic             bu_vld;
  logic             butterfly_finish;
  logic             seq_out_finish_a;
  logic             seq_out_finish_b;
  logic [CNT_W-1:0] length;
  lane_bus_t        bu_indx_a;
  lane_bus_t        bu_indx_b;
  logic             butterfly_start_a;
  logic             butterfly_start_b;
  logic             seq_out_start_a;
  logic             seq_out_start_b;
  logic             write_vld_a;
  logic             write_vld_b;
  lane_bus_t        write_addr_a;
  lane_bus_t        write_addr_b;

  // Expected bank state and outputs
  bank_phase_t m_pa;
  bank_phase_t m_pb;
  int          m_beat_a;
  int          m_beat_b;
  lane_bus_t   exp_addr_a;
  lane_bus_t   exp_addr_b;
  logic        exp_vld_a;
  logic        exp_vld_b;
  logic        exp_bsa;
  logic        exp_bsb;
  logic        exp_ssa;
  logic        exp_ssb;
  int          value_errs;
  int          timeout_errs;
  logic [15:0] lfsr;

  bu_write_addr_gen u_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .up_vld            (up_vld),
    .bu_vld            (bu_vld),
    .butterfly_finish  (butterfly_finish),
    .seq_out_finish_a  (seq_out_finish_a),
    .seq_out_finish_b  (seq_out_finish_b),
    .length            (length),
    .bu_indx_a         (bu_indx_a),
    .bu_indx_b         (bu_indx_b),
    .butterfly_start_a (butterfly_start_a),
    .butterfly_start_b (butterfly_start_b),
    .seq_out_start_a   (seq_out_start_a),
    .seq_out_start_b   (seq_out_start_b),
    .write_vld_a       (write_vld_a),
    .write_vld_b       (write_vld_b),
    .write_addr_a      (write_addr_a),
    .write_addr_b      (write_addr_b)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Random indices
  ////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic lane_bus_t rand_bus();
    logic [BU_PARALLELISM*LANE_W-1:0] flat;
    flat = '0;
    for (int i = 0; i < BU_PARALLELISM * LANE_W; i++)
      flat = {flat[BU_PARALLELISM*LANE_W-2:0], lfsr_bit()};
    return flat;
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Expected {write_vld, write_addr} after the next edge
  function automatic logic [BU_PARALLELISM*LANE_W:0] ref_write(
    input bank_phase_t ph, input int beat, input logic up, input logic bu,
    input lane_bus_t indx, input lane_bus_t held);
    lane_bus_t addr;
    logic      vld;
    addr = held;
    vld  = 1'b0;
    case (ph)
      PH_SEQ_IN: begin
        for (int i = 0; i < BU_PARALLELISM; i++)
          addr[i] = LANE_W'(beat);  // Beat number in every lane
        vld = up;
      end
      PH_BUTTERFLY: begin
        addr = indx;
        vld  = bu;
      end
      PH_SEQ_OUT: addr = '0;
      default:    addr = held;
    endcase
    return {vld, addr};
  endfunction

  task automatic step_model();
    logic [BU_PARALLELISM*LANE_W:0] ra;
    logic [BU_PARALLELISM*LANE_W:0] rb;
    bank_phase_t pa;
    bank_phase_t pb;
    logic bsa;
    logic ssa;
    logic bsb;
    logic ssb;
    int   last_beat;
    last_beat = int'(length) / BU_PARALLELISM - 1;
    ra  = ref_write(m_pa, m_beat_a, up_vld, bu_vld, bu_indx_a, exp_addr_a);
    rb  = ref_write(m_pb, m_beat_b, up_vld, bu_vld, bu_indx_b, exp_addr_b);
    pa  = m_pa;
    pb  = m_pb;
    bsa = 1'b0;
    ssa = 1'b0;
    bsb = 1'b0;
    ssb = 1'b0;
    case (m_pa)
      PH_SEQ_IN: if (up_vld) begin
        if (m_beat_a == last_beat) begin
          m_beat_a = 0;
          pa       = PH_BUTTERFLY;
          bsa      = 1'b1;
        end else m_beat_a = m_beat_a + 1;
      end
      PH_BUTTERFLY: if (butterfly_finish) begin
        pa  = PH_SEQ_OUT;
        ssa = 1'b1;
      end
      PH_SEQ_OUT: if (seq_out_finish_a) pa = PH_SEQ_IN;
      default:    pa = PH_SEQ_IN;
    endcase
    // B follows A's events of this cycle
    case (m_pb)
      PH_IDLE: begin
        if (exp_bsa) pb = PH_SEQ_IN;
        else if (exp_ssa) begin
          pb  = PH_BUTTERFLY;
          bsb = 1'b1;
        end else if (seq_out_finish_a) begin
          pb  = PH_SEQ_OUT;
          ssb = 1'b1;
        end
      end
      PH_SEQ_IN: if (up_vld) begin
        if (m_beat_b == last_beat) begin
          m_beat_b = 0;
          pb       = PH_IDLE;
          if (m_pa != PH_BUTTERFLY || exp_ssa) begin
            pb  = PH_BUTTERFLY;
            bsb = 1'b1;
          end
        end else m_beat_b = m_beat_b + 1;
      end
      PH_BUTTERFLY: if (butterfly_finish) begin
        pb = PH_IDLE;
        if (m_pa != PH_SEQ_OUT || seq_out_finish_a) begin
          pb  = PH_SEQ_OUT;
          ssb = 1'b1;
        end
      end
      PH_SEQ_OUT: if (seq_out_finish_b)
        pb = (m_pa != PH_SEQ_IN || exp_bsa) ? PH_SEQ_IN : PH_IDLE;
      default: pb = PH_IDLE;
    endcase
    {exp_vld_a, exp_addr_a} = ra;
    {exp_vld_b, exp_addr_b} = rb;
    m_pa    = pa;
    m_pb    = pb;
    exp_bsa = bsa;
    exp_ssa = ssa;
    exp_bsb = bsb;
    exp_ssb = ssb;
  endtask

  ////////////////////////////////////////////////////////////
  // Compare tasks and scoring process
  ////////////////////////////////////////////////////////////

  task automatic compare_bus(input string name, input lane_bus_t got, input lane_bus_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic verify_vld(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errs++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic expect_pulse(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errs++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic score_outputs();
    compare_bus("write_addr_a", write_addr_a, exp_addr_a);
    compare_bus("write_addr_b", write_addr_b, exp_addr_b);
    verify_vld("write_vld_a", write_vld_a, exp_vld_a);
    verify_vld("write_vld_b", write_vld_b, exp_vld_b);
    expect_pulse("butterfly_start_a", butterfly_start_a, exp_bsa);
    expect_pulse("butterfly_start_b", butterfly_start_b, exp_bsb);
    expect_pulse("seq_out_start_a", seq_out_start_a, exp_ssa);
    expect_pulse("seq_out_start_b", seq_out_start_b, exp_ssb);
  endtask

  // Settled outputs and stable inputs at the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      m_pa       = PH_SEQ_IN;
      m_pb       = PH_IDLE;
      m_beat_a   = 0;
      m_beat_b   = 0;
      exp_addr_a = '0;
      exp_addr_b = '0;
      exp_vld_a  = 1'b0;
      exp_vld_b  = 1'b0;
      exp_bsa    = 1'b0;
      exp_bsb    = 1'b0;
      exp_ssa    = 1'b0;
      exp_ssb    = 1'b0;
    end
    score_outputs();
    if (rst_n)
      step_model();
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic drive(input logic up, input logic bu, input logic bf,
                       input logic sfa, input logic sfb);
    @(posedge clk);
    up_vld           <= up;
    bu_vld           <= bu;
    butterfly_finish <= bf;
    seq_out_finish_a <= sfa;
    seq_out_finish_b <= sfb;
    bu_indx_a        <= rand_bus();
    bu_indx_b        <= rand_bus();
  endtask

  task automatic idle();
    drive(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic fill_beats(input int n, input logic with_bu);
    repeat (n) drive(1'b1, with_bu, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic wait_pulse(input int sel, input string name);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < WAIT_LIMIT) begin
      @(negedge clk);
      case (sel)
        0:       seen = butterfly_start_a;
        1:       seen = seq_out_start_a;
        2:       seen = butterfly_start_b;
        default: seen = seq_out_start_b;
      endcase
      n++;
    end
    if (!seen) begin
      timeout_errs++;
      $display("Timed out waiting for %s", name);
    end
  endtask

  initial begin
    rst_n            = 1'b0;
    up_vld           = 1'b0;
    bu_vld           = 1'b0;
    butterfly_finish = 1'b0;
    seq_out_finish_a = 1'b0;
    seq_out_finish_b = 1'b0;
    length           = CNT_W'(32);  // 4 beats
    bu_indx_a        = '0;
    bu_indx_b        = '0;
    lfsr             = 16'd41433;
    value_errs       = 0;
    timeout_errs     = 0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    idle();
    idle();
    fill_beats(4, 1'b0);  // Bank A fill
    idle();
    wait_pulse(0, "butterfly_start_a");
    // B fills while A computes and parks until A drains
    fill_beats(4, 1'b1);
    repeat (3) drive(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    drive(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    idle();
    wait_pulse(1, "seq_out_start_a");
    wait_pulse(2, "butterfly_start_b");
    repeat (3) drive(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);  // Beats ignored while A drains
    drive(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    drive(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);  // B compute done
    idle();
    wait_pulse(3, "seq_out_start_b");
    fill_beats(4, 1'b0);  // A refill from beat 0
    idle();
    wait_pulse(0, "butterfly_start_a");
    drive(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    fill_beats(2, 1'b0);
    repeat (4) idle();
    $display("Checks done with %0d value errors and %0d timeouts", value_errs, timeout_errs);
    if (value_errs == 0 && timeout_errs == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule : tb_bu_write_addr_gen

`default_nettype wire

// ==== bu_write_addr_gen.f ====
common/bu_wag_pkg.sv
bank_ctrl/bank_ctrl_a.sv
bank_ctrl/bank_ctrl_b.sv
verilog/write_addr_gen.sv
verilog/bu_write_addr_gen.sv
tests/bu_write_addr_gen_sva.sv
tests/tb_bu_write_addr_gen.sv

// ==== Makefile ====
TOP := tb_bu_write_addr_gen

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f bu_write_addr_gen.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
